// File: include/usb_tx_consts.svh
// ******************************
// Timing, width and line-level constants for the USB transmit path
// Include wherever bit timing or line levels are needed
// ******************************

`ifndef USB_TX_CONSTS_SVH
`define USB_TX_CONSTS_SVH

// Clocks per line bit at 96 MHz
`define USB_BIT_CYCLES 8
// Bit-period counter width
`define USB_BIT_CNT_W 3

// Data byte width
`define USB_BYTE_W 8
// Ones in a row before a zero is stuffed
`define USB_STUFF_RUN 6

// Line levels for J, K and SE0
`define USB_J_DP 1'b1
`define USB_J_DM 1'b0
`define USB_K_DP 1'b0
`define USB_K_DM 1'b1
`define USB_SE0_DP 1'b0
`define USB_SE0_DM 1'b0

`endif

// File: project.f
+incdir+include
source/usb_tx_pkg.sv
source/tx_bit_if.sv
source/bit_timer.sv
source/byte_shifter.sv
source/bit_stuffer.sv
source/nrzi_encoder.sv
source/byte_transmitter.sv
tb/tb_byte_transmitter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the byte transmitter testbench with Verilator.
# The exit status is the simulator's, nonzero on any failure.

cd "$(dirname "$0")" || exit 1

TOP=tb_byte_transmitter
BUILD_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator was not found on PATH"
	exit 1
fi

verilator --binary --timing -f project.f --top-module "$TOP" \
	-Mdir "$BUILD_DIR" -o "sim_$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

"./$BUILD_DIR/sim_$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
fi
exit "$status"

// File: source/bit_stuffer.sv
// ******************************
// Zero insertion after a run of ones
// Forwards the data bit and stalls the shifter for a stuffed zero
// ******************************

`timescale 1ns/1ps
`include "usb_tx_consts.svh"

module bit_stuffer
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      idle,
	tx_bit_if.stuffer bus
);

	// Counter wide enough to reach the run limit
	localparam int RUN_W = $clog2(`USB_STUFF_RUN + 1);
	localparam logic [RUN_W-1:0] RUN_LIMIT = RUN_W'(`USB_STUFF_RUN);

	// Ones sent in a row on the line
	logic [RUN_W-1:0] ones_cnt;
	// Next strobe carries a stuffed zero
	logic             stuff_now;

	assign stuff_now = (ones_cnt == RUN_LIMIT);

	// Shifter holds its bit while the zero goes out
	assign bus.stuff_stall = stuff_now;

	// Data passes straight through unless stuffing
	assign bus.enc_bit = stuff_now ? 1'b0 : bus.data_bit;

	// Count bits actually sent, including the stuffed zero
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ones_cnt <= '0;
		else if (idle)
			ones_cnt <= '0;
		else if (bus.bit_strobe)
		begin
			// Any zero on the line restarts the run
			if (bus.enc_bit)
				ones_cnt <= ones_cnt + 1'b1;
			else
				ones_cnt <= '0;
		end
	end

endmodule

// File: source/bit_timer.sv
// ******************************
// Line bit timer for the transmitter
// Pulses shift_enable once per eight-clock bit period
// ******************************

`timescale 1ns/1ps
`include "usb_tx_consts.svh"

module bit_timer
(
	input  logic clk,
	input  logic rst_n,
	input  logic tim_en,
	input  logic tim_rst,
	output logic shift_enable
);

	// Last count of a bit period
	localparam logic [`USB_BIT_CNT_W-1:0] LAST_CNT = `USB_BIT_CNT_W'(`USB_BIT_CYCLES - 1);

	// Position within the current line bit
	logic [`USB_BIT_CNT_W-1:0] cnt;
	// Timer allowed to count
	logic run;

	// Held clear by tim_rst or a low tim_en
	assign run = tim_en && !tim_rst;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (!run)
			cnt <= '0;
		else if (cnt == LAST_CNT)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// Strobe on the eighth enabled clock
	// First pulse lands eight cycles after release
	assign shift_enable = run && (cnt == LAST_CNT);

endmodule

// File: source/byte_shifter.sv
// ******************************
// Byte source select and LSB-first shift register
// Requests the next byte with load_byte as each byte finishes
// ******************************

`timescale 1ns/1ps
`include "usb_tx_consts.svh"

module byte_shifter
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`USB_BYTE_W-1:0] fsm_byte,
	input  logic [`USB_BYTE_W-1:0] fifo_byte,
	input  logic                   select,
	input  logic                   load_en,
	input  logic                   idle,
	output logic                   load_byte,
	tx_bit_if.shifter              bus
);

	// Bit counter sized to the byte
	localparam int CNT_W = $clog2(`USB_BYTE_W);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`USB_BYTE_W - 1);

	usb_tx_pkg::byte_src_t    src;
	logic [`USB_BYTE_W-1:0]   next_byte;
	logic [`USB_BYTE_W-1:0]   shift_reg;
	logic [CNT_W-1:0]         bit_cnt;
	// A data bit leaves on this strobe
	logic                     advance;
	// Eighth data bit leaves on this strobe
	logic                     end_of_byte;

	assign src = usb_tx_pkg::byte_src_t'(select);

	// Byte source mux
	always_comb
	begin
		case (src)
			usb_tx_pkg::SRC_FSM:  next_byte = fsm_byte;
			default:              next_byte = fifo_byte;
		endcase
	end

	// Stuffed bits and idle hold the register
	assign advance     = bus.bit_strobe && !bus.stuff_stall && !idle;
	assign end_of_byte = advance && (bit_cnt == LAST_BIT);

	// Tells the source that the next byte was just taken
	assign load_byte = end_of_byte;

	// LSB goes to the stuffer
	assign bus.data_bit = shift_reg[0];

	// Data path
	always_ff @(posedge clk)
	begin
		if (load_en || end_of_byte)
			shift_reg <= next_byte;
		else if (advance)
			shift_reg <= {1'b0, shift_reg[`USB_BYTE_W-1:1]};
	end

	// Count of data bits already sent from this byte
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (load_en || end_of_byte)
			bit_cnt <= '0;
		else if (advance)
			bit_cnt <= bit_cnt + 1'b1;
	end

endmodule

// File: source/byte_transmitter.sv
// ******************************
// Transmit datapath top level
// Timer, shifter, stuffer and NRZI encoder on plain ports
// ******************************

`timescale 1ns/1ps
`include "usb_tx_consts.svh"

module byte_transmitter
(
	input  logic                   clk,
	input  logic                   rst_n,
	// Byte from the packet-control FSM
	input  logic [`USB_BYTE_W-1:0] fsm_byte,
	// Byte from the data FIFO
	input  logic [`USB_BYTE_W-1:0] fifo_byte,
	input  logic                   select,
	input  logic                   load_en,
	input  logic                   idle,
	input  logic                   tim_en,
	input  logic                   tim_rst,
	input  logic                   eop,
	output logic                   d_plus,
	output logic                   d_minus,
	output logic                   load_byte,
	output logic                   shift_enable
);

	// Per-bit bundle between the datapath blocks
	tx_bit_if bus ();

	// Bit period strobe
	bit_timer u_timer
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.tim_en       (tim_en),
		.tim_rst      (tim_rst),
		.shift_enable (shift_enable)
	);

	// Timer output is the strobe for every block
	assign bus.bit_strobe = shift_enable;

	// Byte load and LSB-first shift
	byte_shifter u_shifter
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.fsm_byte  (fsm_byte),
		.fifo_byte (fifo_byte),
		.select    (select),
		.load_en   (load_en),
		.idle      (idle),
		.load_byte (load_byte),
		.bus       (bus.shifter)
	);

	// Zero after six ones
	bit_stuffer u_stuffer
	(
		.clk   (clk),
		.rst_n (rst_n),
		.idle  (idle),
		.bus   (bus.stuffer)
	);

	// Line driver
	nrzi_encoder u_encoder
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.idle    (idle),
		.eop     (eop),
		.bus     (bus.encoder),
		.d_plus  (d_plus),
		.d_minus (d_minus)
	);

endmodule

// File: source/nrzi_encoder.sv
// ******************************
// NRZI line driver for d_plus and d_minus
// Holds J when idle and SE0 while eop is high
// ******************************

`timescale 1ns/1ps
`include "usb_tx_consts.svh"

module nrzi_encoder
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      idle,
	input  logic      eop,
	tx_bit_if.encoder bus,
	output logic      d_plus,
	output logic      d_minus
);

	usb_tx_pkg::line_state_t line_q;
	usb_tx_pkg::line_state_t line_d;

	// Next line state
	always_comb
	begin
		line_d = line_q;
		if (eop)
			line_d = usb_tx_pkg::LINE_SE0;
		else if (idle)
			line_d = usb_tx_pkg::LINE_J;
		else if (bus.bit_strobe)
		begin
			// A one keeps the level and a zero toggles it
			case (line_q)
				usb_tx_pkg::LINE_J: line_d = bus.enc_bit ? usb_tx_pkg::LINE_J : usb_tx_pkg::LINE_K;
				usb_tx_pkg::LINE_K: line_d = bus.enc_bit ? usb_tx_pkg::LINE_K : usb_tx_pkg::LINE_J;
				// Coming out of SE0 the reference level is J
				default:            line_d = bus.enc_bit ? usb_tx_pkg::LINE_J : usb_tx_pkg::LINE_K;
			endcase
		end
	end

	// Line starts at J after reset
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			line_q <= usb_tx_pkg::LINE_J;
		else
			line_q <= line_d;
	end

	// Pin levels from the state
	always_comb
	begin
		case (line_q)
			usb_tx_pkg::LINE_J:
			begin
				d_plus  = `USB_J_DP;
				d_minus = `USB_J_DM;
			end
			usb_tx_pkg::LINE_K:
			begin
				d_plus  = `USB_K_DP;
				d_minus = `USB_K_DM;
			end
			default:
			begin
				d_plus  = `USB_SE0_DP;
				d_minus = `USB_SE0_DM;
			end
		endcase
	end

endmodule

// File: source/tx_bit_if.sv
// ******************************
// Per-bit signals shared by shifter, stuffer and encoder
// One instance lives in the transmitter top level
// ******************************

`timescale 1ns/1ps

interface tx_bit_if;

	// One-cycle pulse at each line bit boundary
	logic bit_strobe;
	// Current LSB of the shift register
	logic data_bit;
	// High while a stuffed zero replaces the data bit
	logic stuff_stall;
	// Bit actually placed on the line
	logic enc_bit;

	// Shift register side
	modport shifter
	(
		input  bit_strobe,
		input  stuff_stall,
		output data_bit
	);

	// Bit stuffer sits between shifter and encoder
	modport stuffer
	(
		input  bit_strobe,
		input  data_bit,
		output stuff_stall,
		output enc_bit
	);

	// NRZI encoder only consumes
	modport encoder
	(
		input bit_strobe,
		input enc_bit
	);

endinterface

// File: source/usb_tx_pkg.sv
// ******************************
// Shared types for the USB transmit datapath
// Referenced by scoped name from the RTL and testbench
// ******************************

package usb_tx_pkg;

	// Line state held by the NRZI encoder
	// Bit 1 follows d_plus and bit 0 follows d_minus
	typedef enum logic [1:0]
	{
		LINE_SE0 = 2'b00,
		LINE_K   = 2'b01,
		LINE_J   = 2'b10
	} line_state_t;

	// Source of the next byte to shift out
	typedef enum logic
	{
		SRC_FIFO = 1'b0,
		SRC_FSM  = 1'b1
	} byte_src_t;

endpackage

// File: tb/tb_byte_transmitter.sv
// ******************************
// Random-stimulus testbench for the USB byte transmitter
// Decodes the NRZI line, strips stuffed zeros, checks bytes
// ******************************

`timescale 1ns/1ps
`include "usb_tx_consts.svh"

module tb_byte_transmitter;

	// 40 bytes of up to 10 line bits at 8 clocks each, plus idle gaps and margin
	localparam int MAX_CYCLES   = 6000;
	localparam int RANDOM_BYTES = 30;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic [`USB_BYTE_W-1:0] fsm_byte;
	logic [`USB_BYTE_W-1:0] fifo_byte;
	logic                   select;
	logic                   load_en;
	logic                   idle;
	logic                   tim_en;
	logic                   tim_rst;
	logic                   eop;
	logic                   d_plus;
	logic                   d_minus;
	logic                   load_byte;
	logic                   shift_enable;

	integer seed;
	// Bytes of the next packet
	logic [`USB_BYTE_W-1:0] pkt[$];
	// Data bits still owed by the line, LSB first
	bit exp_bits[$];

	// Line monitor state
	int         cycle_cnt      = 0;
	int         gap            = 0;
	int         strobe_cnt     = 0;
	int         load_cnt       = 0;
	int         stuff_cnt      = 0;
	int         ones_run       = 0;
	bit         decode_pending = 1'b0;
	logic [1:0] prev_line      = 2'b10;

	byte_transmitter u_dut
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.fsm_byte     (fsm_byte),
		.fifo_byte    (fifo_byte),
		.select       (select),
		.load_en      (load_en),
		.idle         (idle),
		.tim_en       (tim_en),
		.tim_rst      (tim_rst),
		.eop          (eop),
		.d_plus       (d_plus),
		.d_minus      (d_minus),
		.load_byte    (load_byte),
		.shift_enable (shift_enable)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	task automatic end_in_failure();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compare_values
	(
		input logic [31:0] actual,
		input logic [31:0] expected,
		input string       msg
	);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
			end_in_failure();
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		end_in_failure();
	endtask

	// Destuff one decoded line bit and match it against the queue
	task automatic take_line_bit(input bit line_bit);
		bit want;
		if (ones_run == `USB_STUFF_RUN)
		begin
			// Bit after six ones is the stuffed zero
			compare_values(32'(line_bit), 32'h0, "stuffed bit after six ones");
			stuff_cnt++;
			ones_run = 0;
		end
		else if (exp_bits.size() == 0)
			report_problem("A data bit appeared on the line with no byte queued");
		else
		begin
			want = exp_bits.pop_front();
			compare_values(32'(line_bit), 32'(want), "decoded data bit");
			ones_run = line_bit ? ones_run + 1 : 0;
		end
	endtask

	task automatic queue_bits(input logic [`USB_BYTE_W-1:0] value);
		for (int i = 0; i < `USB_BYTE_W; i++)
			exp_bits.push_back(value[i]);
	endtask

	// Chosen source gets the byte, the other one its complement
	task automatic present_byte(input logic [`USB_BYTE_W-1:0] value,
		input usb_tx_pkg::byte_src_t src);
		if (src == usb_tx_pkg::SRC_FSM)
		begin
			fsm_byte  = value;
			fifo_byte = ~value;
		end
		else
		begin
			fifo_byte = value;
			fsm_byte  = ~value;
		end
		queue_bits(value);
	endtask

	// Returns on the falling edge after the next strobe
	task automatic wait_strobe();
		int start;
		start = strobe_cnt;
		while (strobe_cnt == start)
			@(negedge clk);
	endtask

	// Sends pkt back to back, next byte offered after each load_byte
	task automatic send_packet(input usb_tx_pkg::byte_src_t src);
		int n;
		int loads_at_start;
		n = pkt.size();
		loads_at_start = load_cnt;
		wait_strobe();
		select = src;
		present_byte(pkt[0], src);
		load_en = 1'b1;
		idle = 1'b0;
		@(negedge clk);
		load_en = 1'b0;
		if (n > 1)
			present_byte(pkt[1], src);
		for (int k = 1; k <= n; k++)
		begin
			while (load_cnt < loads_at_start + k)
				@(negedge clk);
			if (k + 1 < n)
				present_byte(pkt[k + 1], src);
		end
		// Last data bit is out, back to idle
		idle = 1'b1;
		wait_strobe();
		compare_values(load_cnt, loads_at_start + n, "load_byte pulses in packet");
	endtask

	// Line monitor, samples settled values at the rising edge
	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES)
			report_problem("Run hit the cycle limit before all tests finished");
		else if (rst_n)
		begin
			if (tim_en && !tim_rst)
			begin
				gap++;
				if (shift_enable)
				begin
					compare_values(gap, `USB_BIT_CYCLES, "shift_enable spacing");
					gap = 0;
					strobe_cnt++;
				end
			end
			else
			begin
				gap = 0;
				compare_values(32'(shift_enable), 32'h0, "shift_enable while timer held");
			end
			if (load_byte)
			begin
				compare_values(32'(shift_enable), 32'h1, "load_byte away from a strobe");
				load_cnt++;
			end
			// Unchanged level is a one, a change is a zero
			if (decode_pending)
			begin
				decode_pending = 1'b0;
				if (d_plus == d_minus)
					report_problem("Line was SE0 in the middle of a packet");
				else
					take_line_bit({d_plus, d_minus} == prev_line);
			end
			if (shift_enable && !idle && !eop)
			begin
				prev_line = {d_plus, d_minus};
				decode_pending = 1'b1;
			end
			if (idle)
				ones_run = 0;
		end
	end

	initial
	begin
		int strobes_before;
		int stuffs_before;
		seed      = 32'h3fcb5225;
		rst_n     = 1'b0;
		fsm_byte  = '0;
		fifo_byte = '0;
		select    = 1'b0;
		load_en   = 1'b0;
		idle      = 1'b1;
		tim_en    = 1'b0;
		tim_rst   = 1'b1;
		eop       = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Quiet outputs and J after reset
		compare_values(32'(d_plus), 32'(`USB_J_DP), "d_plus after reset");
		compare_values(32'(d_minus), 32'(`USB_J_DM), "d_minus after reset");
		compare_values(32'(shift_enable), 32'h0, "shift_enable after reset");
		compare_values(32'(load_byte), 32'h0, "load_byte after reset");

		// Timer running while idle, line holds J
		tim_en = 1'b1;
		tim_rst = 1'b0;
		strobes_before = strobe_cnt;
		repeat (3 * `USB_BIT_CYCLES)
		begin
			@(negedge clk);
			compare_values(32'({d_plus, d_minus}), 32'({`USB_J_DP, `USB_J_DM}), "idle line");
		end
		compare_values(strobe_cnt, strobes_before + 3, "strobes in three bit periods");

		// Mid-period hold by tim_rst restarts the bit period
		repeat (3) @(negedge clk);
		tim_rst = 1'b1;
		repeat (`USB_BIT_CYCLES) @(negedge clk);
		tim_rst = 1'b0;

		// Low tim_en holds the counter the same way
		repeat (3) @(negedge clk);
		tim_en = 1'b0;
		repeat (`USB_BIT_CYCLES) @(negedge clk);
		tim_en = 1'b1;
		strobes_before = strobe_cnt;
		repeat (2 * `USB_BIT_CYCLES) @(negedge clk);
		compare_values(strobe_cnt, strobes_before + 2, "strobes after timer hold");

		// Random FIFO bytes back to back
		pkt.delete();
		repeat (RANDOM_BYTES)
			pkt.push_back(8'($random(seed)));
		send_packet(usb_tx_pkg::SRC_FIFO);

		// 16 ones, a zero, then 7 ones, so three stuffed zeros
		stuffs_before = stuff_cnt;
		pkt.delete();
		pkt.push_back(8'hFF);
		pkt.push_back(8'hFF);
		pkt.push_back(8'hFE);
		send_packet(usb_tx_pkg::SRC_FIFO);
		compare_values(stuff_cnt, stuffs_before + 3, "stuffed zeros for FF FF FE");

		// Sync byte from the FSM side
		pkt.delete();
		pkt.push_back(8'h80);
		send_packet(usb_tx_pkg::SRC_FSM);

		// End of packet drives SE0
		eop = 1'b1;
		repeat (2 * `USB_BIT_CYCLES)
		begin
			@(negedge clk);
			compare_values(32'({d_plus, d_minus}), 32'({`USB_SE0_DP, `USB_SE0_DM}), "SE0 line");
		end
		eop = 1'b0;
		@(negedge clk);
		compare_values(32'({d_plus, d_minus}), 32'({`USB_J_DP, `USB_J_DM}), "J after eop");

		if (exp_bits.size() != 0)
			report_problem("Some queued data bits never appeared on the line");
		else
		begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule
